// File: Bender.yml
package:
  name: saturn_control_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/saturn_pkg.sv
      - verilog/saturn_cmd_sequencer.sv
      - verilog/saturn_bus_program.sv
      - verilog/saturn_exec_regs.sv
      - verilog/saturn_control_unit.sv
  - target: test
    include_dirs:
      - include
      - dv
    files:
      - dv/tb_saturn_control_unit.sv

// File: dv/saturn_tb_model.svh
// Reference model of the control unit for the testbench; include inside the testbench top module
`ifndef SATURN_TB_MODEL_SVH
`define SATURN_TB_MODEL_SVH

// Pending store writes, codes below ENTRY_LOAD_PC are PC nibble indexes
localparam int ENTRY_LOAD_PC = 8;
localparam int ENTRY_RESET   = 9;
localparam int ENTRY_PC_READ = 10;

logic [31:0]                 lcg_state = 32'h78c315c2;
logic [`SATURN_NIBBLE_W-1:0] exp_p;
logic [`SATURN_NIBBLE_W-1:0] exp_hst;
logic [`SATURN_ST_W-1:0]     exp_st;
logic                        exp_mode;
logic [`SATURN_NIBBLE_W-1:0] exp_c [`SATURN_C_NIBBLES];
prog_word_t                  exp_prog [`SATURN_PROG_DEPTH];
logic                        exp_valid [`SATURN_PROG_DEPTH];   // Entry written since reset
logic [`SATURN_PROG_AW-1:0]  exp_wptr;
int                          pending [$];

function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic dec_instr_t make_instr(instr_type_e t, alu_op_e op, alu_reg_e dst,
                                          alu_reg_e src, logic [3:0] ptr, logic [3:0] imm);
    dec_instr_t ins;
    ins.instr_type = t;
    ins.alu_op     = op;
    ins.reg_dest   = dst;
    ins.reg_src    = src;
    ins.ptr_begin  = ptr;
    ins.imm        = imm;
    return ins;
endfunction

// LOAD_PC command, then the PC nibbles low first
function void queue_load_pc();
    pending.push_back(ENTRY_LOAD_PC);
    for (int k = 0; k < `SATURN_PC_NIBBLES; k++) begin
        pending.push_back(k);
    end
endfunction

function void reset_model();
    exp_p    = '0;
    exp_hst  = '0;
    exp_st   = '0;
    exp_mode = 1'b0;
    exp_wptr = '0;
    for (int k = 0; k < `SATURN_C_NIBBLES; k++) begin
        exp_c[k] = '0;
    end
    for (int k = 0; k < `SATURN_PROG_DEPTH; k++) begin
        exp_valid[k] = 1'b0;
    end
    pending.delete();
    queue_load_pc();
endfunction

function void write_next_entry();
    int         code;
    prog_word_t w;
    code     = pending.pop_front();
    w.is_cmd = (code >= ENTRY_LOAD_PC);
    case (code)
        ENTRY_LOAD_PC: w.nibble = BUSCMD_LOAD_PC;
        ENTRY_RESET:   w.nibble = BUSCMD_RESET;
        ENTRY_PC_READ: w.nibble = BUSCMD_PC_READ;
        default:       w.nibble = i_pc[code * `SATURN_NIBBLE_W +: `SATURN_NIBBLE_W];
    endcase
    exp_prog[exp_wptr]  = w;
    exp_valid[exp_wptr] = 1'b1;
    exp_wptr            = exp_wptr + 1'b1;   // Wraps at the store depth
endfunction

// Register effects of one executed instruction
function void apply_instr(dec_instr_t ins);
    logic copy;
    logic clr;
    copy = (ins.instr_type == INSTR_ALU) && (ins.alu_op == ALU_OP_COPY);
    clr  = (ins.instr_type == INSTR_ALU) && (ins.alu_op == ALU_OP_CLR_MASK);
    if (copy && ins.reg_dest == ALU_REG_P && ins.reg_src == ALU_REG_IMM) begin
        exp_p = ins.imm;
    end else if (copy && ins.reg_dest == ALU_REG_C && ins.reg_src == ALU_REG_P) begin
        exp_c[ins.ptr_begin] = exp_p;
    end else if (copy && ins.reg_dest == ALU_REG_ST && ins.reg_src == ALU_REG_IMM) begin
        exp_st[ins.ptr_begin] = ins.imm[0];
    end else if (clr && ins.reg_dest == ALU_REG_HST && ins.reg_src == ALU_REG_IMM) begin
        exp_hst = exp_hst & ~ins.imm;
    end else if (ins.instr_type == INSTR_SET_MODE) begin
        exp_mode = ins.imm[0];
    end else if (ins.instr_type == INSTR_LOAD && ins.reg_dest == ALU_REG_C) begin
        exp_c[ins.ptr_begin] = ins.imm;
    end
endfunction

`endif

// File: dv/tb_saturn_control_unit.sv
// Testbench for the Saturn control unit; drives random instructions and checks against a model
`timescale 1ns/1ps
`default_nettype none

`include "saturn_consts.svh"

module tb_saturn_control_unit
    import saturn_pkg::*;
();

    localparam int PLANNED_CYCLES = 8 + 8 + 3 * 16 + 64 + 16 + 4 * 4 + 6 * 8 + 32;
    localparam int TIMEOUT_CYCLES = 2 * PLANNED_CYCLES;

    logic                        i_clk = 1'b0;
    logic                        i_reset;
    logic                        i_exec;
    dec_instr_t                  i_instr;
    logic                        i_bus_busy;
    logic [`SATURN_PC_W-1:0]     i_pc;
    logic                        i_reload_pc;
    logic [`SATURN_PROG_AW-1:0]  i_prog_addr;
    logic [`SATURN_NIBBLE_W-1:0] i_c_ptr;
    logic                        o_ready;
    prog_word_t                  o_prog_data;
    logic [`SATURN_PROG_AW-1:0]  o_prog_wptr;
    logic [`SATURN_NIBBLE_W-1:0] o_reg_p;
    logic [`SATURN_NIBBLE_W-1:0] o_reg_hst;
    logic [`SATURN_ST_W-1:0]     o_reg_st;
    logic                        o_alu_mode;
    logic [`SATURN_NIBBLE_W-1:0] o_c_nibble;
    int                          cycle_count = 0;

    `include "saturn_tb_model.svh"

    saturn_control_unit saturn_control_unit_i (.*);

    always #2 i_clk = ~i_clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Verification failed");
            $fatal(1, "Stopping at first error");
        end
    endtask

    task automatic compare_outputs();
        check_value("o_ready", o_ready, pending.size() == 0);
        check_value("o_prog_wptr", o_prog_wptr, exp_wptr);
        check_value("o_reg_p", o_reg_p, exp_p);
        check_value("o_reg_hst", o_reg_hst, exp_hst);
        check_value("o_reg_st", o_reg_st, exp_st);
        check_value("o_alu_mode", o_alu_mode, exp_mode);
        check_value("o_c_nibble", o_c_nibble, exp_c[i_c_ptr]);
        if (exp_valid[i_prog_addr]) begin
            check_value("o_prog_data", o_prog_data, exp_prog[i_prog_addr]);
        end
    endtask

    // Called on a falling edge, holds the strobe for one cycle
    task automatic issue(input dec_instr_t ins, input logic busy);
        i_instr    = ins;
        i_exec     = 1'b1;
        i_bus_busy = busy;
        @(negedge i_clk);
        i_exec     = 1'b0;
        i_bus_busy = 1'b0;
    endtask

    task automatic wait_ready();
        while (!o_ready) begin
            @(negedge i_clk);
        end
    endtask

    // Compare first, then advance the model by what this edge takes in
    always @(posedge i_clk) begin
        if (i_reset) begin
            reset_model();
        end else begin
            compare_outputs();
            if (pending.size() != 0) begin
                write_next_entry();
            end else begin
                if (i_exec && !i_bus_busy) begin
                    apply_instr(i_instr);
                end
                if (i_reload_pc) begin
                    queue_load_pc();
                end else if (i_exec && !i_bus_busy && i_instr.instr_type == INSTR_RESET) begin
                    pending.push_back(ENTRY_RESET);
                    pending.push_back(ENTRY_PC_READ);
                end
            end
        end
    end

    // Read-back sweep of every C nibble and store entry
    always @(negedge i_clk) begin
        i_c_ptr     = i_c_ptr + 1'b1;
        i_prog_addr = i_prog_addr + 1'b1;
    end

    always @(posedge i_clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $fatal(1, "Simulation stopped");
        end
    end

    initial begin
        int          cycles;
        logic [31:0] r;
        logic [4:0]  wptr_before;
        r           = lcg_next();
        i_reset     = 1'b1;
        i_exec      = 1'b0;
        i_instr     = '0;
        i_bus_busy  = 1'b0;
        i_pc        = r[`SATURN_PC_W-1:0];
        i_reload_pc = 1'b0;
        i_prog_addr = '0;
        i_c_ptr     = '0;
        repeat (8) @(negedge i_clk);
        i_reset = 1'b0;

        cycles = 0;   // Startup LOAD_PC sequence
        do begin
            @(posedge i_clk);
            cycles++;
        end while (!o_ready);
        check_value("ready_delay", cycles, 7);
        check_value("o_prog_wptr", o_prog_wptr, 6);
        @(negedge i_clk);

        for (int k = 0; k < 16; k++) begin
            r = lcg_next();
            issue(make_instr(INSTR_ALU, ALU_OP_COPY, ALU_REG_P, ALU_REG_IMM, 4'd0, r[3:0]), 1'b0);
            issue(make_instr(INSTR_ALU, ALU_OP_COPY, ALU_REG_C, ALU_REG_P, 4'(k), 4'd0), 1'b0);
            issue(make_instr(INSTR_LOAD, ALU_OP_COPY, ALU_REG_C, ALU_REG_A, r[11:8], r[7:4]),
                  1'b0);
        end

        for (int k = 0; k < 64; k++) begin
            r = lcg_next();
            case (r[9:8])
                2'd0: issue(make_instr(INSTR_ALU, ALU_OP_CLR_MASK, ALU_REG_HST, ALU_REG_IMM,
                                       4'd0, r[3:0]), 1'b0);
                2'd1: issue(make_instr(INSTR_ALU, ALU_OP_COPY, ALU_REG_ST, ALU_REG_IMM,
                                       r[7:4], r[3:0]), 1'b0);
                2'd2: issue(make_instr(INSTR_SET_MODE, ALU_OP_COPY, ALU_REG_A, ALU_REG_A,
                                       4'd0, r[3:0]), 1'b0);
                default: issue(make_instr(INSTR_JUMP, ALU_OP_COPY, ALU_REG_P, ALU_REG_IMM,
                                          r[7:4], r[3:0]), 1'b0);   // Must be ignored
            endcase
        end

        wptr_before = o_prog_wptr;
        for (int k = 0; k < 16; k++) begin
            r = lcg_next();
            issue(make_instr(r[8] ? INSTR_RESET : INSTR_LOAD, ALU_OP_COPY, ALU_REG_C,
                             ALU_REG_A, r[7:4], r[3:0]), 1'b1);
        end
        check_value("o_prog_wptr", o_prog_wptr, wptr_before);

        for (int k = 0; k < 4; k++) begin
            wptr_before = o_prog_wptr;
            issue(make_instr(INSTR_RESET, ALU_OP_COPY, ALU_REG_A, ALU_REG_A, 4'd0, 4'd0), 1'b0);
            wait_ready();
            check_value("o_prog_wptr", o_prog_wptr, 5'(wptr_before + 5'd2));
        end

        do begin
            wptr_before = o_prog_wptr;
            r           = lcg_next();
            i_pc        = r[`SATURN_PC_W-1:0];
            i_reload_pc = 1'b1;
            @(negedge i_clk);
            i_reload_pc = 1'b0;
            wait_ready();
        end while (o_prog_wptr > wptr_before);   // Stop once the pointer wrapped

        repeat (32) @(negedge i_clk);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: include/saturn_consts.svh
// Widths and depths of the Saturn control unit; include wherever storage or ports are sized
`ifndef SATURN_CONSTS_SVH
`define SATURN_CONSTS_SVH

// Basic data unit of the Saturn datapath
`define SATURN_NIBBLE_W     4

// Program counter
`define SATURN_PC_W         20
`define SATURN_PC_NIBBLES   5

// Status bits ST0..ST15
`define SATURN_ST_W         16

// Working register C is sixteen nibbles wide
`define SATURN_C_NIBBLES    16

// Bus program store
`define SATURN_PROG_DEPTH   32
`define SATURN_PROG_AW      5

`endif

// File: verilog/saturn_bus_program.sv
// Bus program store: written in order at its own pointer, read by address from the bus controller
`timescale 1ns/1ps
`default_nettype none

`include "saturn_consts.svh"

module saturn_bus_program
    import saturn_pkg::*;
(
    input  logic                       i_clk,
    input  logic                       i_reset,
    input  logic                       i_we,
    input  prog_word_t                 i_wdata,
    input  logic [`SATURN_PROG_AW-1:0] i_raddr,
    output prog_word_t                 o_rdata,
    output logic [`SATURN_PROG_AW-1:0] o_wptr
);

    prog_word_t mem [`SATURN_PROG_DEPTH];

    always_ff @(posedge i_clk) begin
        if (i_we) begin
            mem[o_wptr] <= i_wdata;
        end
    end

    // Pointer wraps at the store depth
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_wptr <= '0;
        end else if (i_we) begin
            o_wptr <= o_wptr + 1'b1;
        end
    end

    assign o_rdata = mem[i_raddr]; // Asynchronous read port

    a_wptr_step: assert property (@(posedge i_clk) disable iff (i_reset)
        1'b1 |=> o_wptr == $past(o_wptr) + {{(`SATURN_PROG_AW-1){1'b0}}, $past(i_we)});

endmodule

`default_nettype wire

// File: verilog/saturn_cmd_sequencer.sv
// Command sequencer that writes LOAD_PC and RESET sequences into the bus program and gates execution
`timescale 1ns/1ps
`default_nettype none

`include "saturn_consts.svh"

module saturn_cmd_sequencer
    import saturn_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_reset,
    input  logic                    i_exec,
    input  instr_type_e             i_instr_type,
    input  logic                    i_bus_busy,
    input  logic [`SATURN_PC_W-1:0] i_pc,
    input  logic                    i_reload_pc,
    output logic                    o_ready,
    output logic                    o_exec_fire,
    output logic                    o_prog_we,
    output prog_word_t              o_prog_wdata
);

    localparam logic [2:0] LAST_NIBBLE = 3'(`SATURN_PC_NIBBLES - 1);

    seq_state_e                  state;
    logic [2:0]                  nib_cnt;   // PC nibble index and RESET/PC_READ step
    logic [`SATURN_NIBBLE_W-1:0] pc_nibble;
    logic                        fire_reset;

    assign pc_nibble   = i_pc[nib_cnt * `SATURN_NIBBLE_W +: `SATURN_NIBBLE_W];
    assign o_ready     = (state == SEQ_READY);
    assign o_exec_fire = o_ready && i_exec && !i_bus_busy;
    assign fire_reset  = o_exec_fire && (i_instr_type == INSTR_RESET);

    // One store entry per cycle outside READY
    always_comb begin
        o_prog_we    = 1'b0;
        o_prog_wdata = '0;
        case (state)
            SEQ_LOAD_CMD: begin
                o_prog_we           = 1'b1;
                o_prog_wdata.is_cmd = 1'b1;
                o_prog_wdata.nibble = BUSCMD_LOAD_PC;
            end
            SEQ_PC_NIBBLES: begin
                o_prog_we           = 1'b1;
                o_prog_wdata.nibble = pc_nibble; // Low nibble first
            end
            SEQ_PC_READ: begin
                o_prog_we           = 1'b1;
                o_prog_wdata.is_cmd = 1'b1;
                o_prog_wdata.nibble = (nib_cnt == 3'd0) ? BUSCMD_RESET : BUSCMD_PC_READ;
            end
            default: ;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state   <= SEQ_LOAD_CMD;
            nib_cnt <= '0;
        end else begin
            case (state)
                SEQ_LOAD_CMD: begin
                    state   <= SEQ_PC_NIBBLES;
                    nib_cnt <= '0;
                end
                SEQ_PC_NIBBLES: begin
                    nib_cnt <= nib_cnt + 3'd1;
                    if (nib_cnt == LAST_NIBBLE) begin
                        state <= SEQ_READY;
                    end
                end
                SEQ_READY: begin
                    nib_cnt <= '0;
                    // A reload wins over a RESET fired in the same cycle
                    if (i_reload_pc) begin
                        state <= SEQ_LOAD_CMD;
                    end else if (fire_reset) begin
                        state <= SEQ_PC_READ;
                    end
                end
                SEQ_PC_READ: begin
                    nib_cnt <= nib_cnt + 3'd1;
                    if (nib_cnt != 3'd0) begin
                        state <= SEQ_READY;        // Back to READY after PC_READ
                    end
                end
                default: state <= SEQ_LOAD_CMD;
            endcase
        end
    end

    // LOAD_PC is followed by five nibble writes without execution and then READY
    a_pc_nibble_burst: assert property (@(posedge i_clk) disable iff (i_reset)
        (state == SEQ_LOAD_CMD) |=>
            (o_prog_we && !o_prog_wdata.is_cmd && !o_exec_fire)[*`SATURN_PC_NIBBLES]
            ##1 o_ready);

    // A fired RESET is followed by the RESET then PC_READ entries
    a_reset_pair: assert property (@(posedge i_clk) disable iff (i_reset)
        (fire_reset && !i_reload_pc) |=>
            (o_prog_we && o_prog_wdata.is_cmd && o_prog_wdata.nibble == BUSCMD_RESET)
            ##1 (o_prog_we && o_prog_wdata.is_cmd && o_prog_wdata.nibble == BUSCMD_PC_READ));

endmodule

`default_nettype wire

// File: verilog/saturn_control_unit.sv
// Saturn control unit top: sequencer, bus program store and register execution unit
`timescale 1ns/1ps
`default_nettype none

`include "saturn_consts.svh"

module saturn_control_unit
    import saturn_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_exec,
    input  dec_instr_t                  i_instr,
    input  logic                        i_bus_busy,
    input  logic [`SATURN_PC_W-1:0]     i_pc,
    input  logic                        i_reload_pc,
    input  logic [`SATURN_PROG_AW-1:0]  i_prog_addr,
    input  logic [`SATURN_NIBBLE_W-1:0] i_c_ptr,
    output logic                        o_ready,
    output prog_word_t                  o_prog_data,
    output logic [`SATURN_PROG_AW-1:0]  o_prog_wptr,
    output logic [`SATURN_NIBBLE_W-1:0] o_reg_p,
    output logic [`SATURN_NIBBLE_W-1:0] o_reg_hst,
    output logic [`SATURN_ST_W-1:0]     o_reg_st,
    output logic                        o_alu_mode,
    output logic [`SATURN_NIBBLE_W-1:0] o_c_nibble
);

    logic       prog_we;
    prog_word_t prog_wdata;
    logic       exec_fire;   // Ready, strobed and bus idle

    saturn_cmd_sequencer saturn_cmd_sequencer_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_exec       (i_exec),
        .i_instr_type (i_instr.instr_type),
        .i_bus_busy   (i_bus_busy),
        .i_pc         (i_pc),
        .i_reload_pc  (i_reload_pc),
        .o_ready      (o_ready),
        .o_exec_fire  (exec_fire),
        .o_prog_we    (prog_we),
        .o_prog_wdata (prog_wdata)
    );

    // Read side belongs to the external bus controller
    saturn_bus_program saturn_bus_program_i (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .i_we    (prog_we),
        .i_wdata (prog_wdata),
        .i_raddr (i_prog_addr),
        .o_rdata (o_prog_data),
        .o_wptr  (o_prog_wptr)
    );

    saturn_exec_regs saturn_exec_regs_i (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_fire     (exec_fire),
        .i_instr    (i_instr),
        .i_c_ptr    (i_c_ptr),
        .o_reg_p    (o_reg_p),
        .o_reg_hst  (o_reg_hst),
        .o_reg_st   (o_reg_st),
        .o_alu_mode (o_alu_mode),
        .o_c_nibble (o_c_nibble)
    );

endmodule

`default_nettype wire

// File: verilog/saturn_exec_regs.sv
// Register execution unit: applies fired instructions to P, HST, ST, mode and C
`timescale 1ns/1ps
`default_nettype none

`include "saturn_consts.svh"

module saturn_exec_regs
    import saturn_pkg::*;
(
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_fire,
    input  dec_instr_t                  i_instr,
    input  logic [`SATURN_NIBBLE_W-1:0] i_c_ptr,
    output logic [`SATURN_NIBBLE_W-1:0] o_reg_p,
    output logic [`SATURN_NIBBLE_W-1:0] o_reg_hst,
    output logic [`SATURN_ST_W-1:0]     o_reg_st,
    output logic                        o_alu_mode,
    output logic [`SATURN_NIBBLE_W-1:0] o_c_nibble
);

    logic [`SATURN_C_NIBBLES-1:0][`SATURN_NIBBLE_W-1:0] reg_c;

    logic alu_copy;
    logic alu_clr_mask;
    logic do_p_eq_n;
    logic do_c_eq_p;
    logic do_clr_hst;
    logic do_st_eq;
    logic do_set_mode;
    logic do_load_c;

    // Instruction field decode
    assign alu_copy     = (i_instr.instr_type == INSTR_ALU) && (i_instr.alu_op == ALU_OP_COPY);
    assign alu_clr_mask = (i_instr.instr_type == INSTR_ALU) &&
                          (i_instr.alu_op == ALU_OP_CLR_MASK);

    assign do_p_eq_n   = alu_copy && (i_instr.reg_dest == ALU_REG_P) &&
                         (i_instr.reg_src == ALU_REG_IMM);
    assign do_c_eq_p   = alu_copy && (i_instr.reg_dest == ALU_REG_C) &&
                         (i_instr.reg_src == ALU_REG_P);
    assign do_clr_hst  = alu_clr_mask && (i_instr.reg_dest == ALU_REG_HST) &&
                         (i_instr.reg_src == ALU_REG_IMM);
    assign do_st_eq    = alu_copy && (i_instr.reg_dest == ALU_REG_ST) &&
                         (i_instr.reg_src == ALU_REG_IMM);
    assign do_set_mode = (i_instr.instr_type == INSTR_SET_MODE);   // SETHEX / SETDEC
    assign do_load_c   = (i_instr.instr_type == INSTR_LOAD) && (i_instr.reg_dest == ALU_REG_C);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_reg_p    <= '0;
            o_reg_hst  <= '0;
            o_reg_st   <= '0;
            o_alu_mode <= 1'b0;
            reg_c      <= '0;   // Whole of C in one cycle
        end else if (i_fire) begin
            if (do_p_eq_n) begin
                o_reg_p <= i_instr.imm;
            end
            if (do_c_eq_p) begin
                reg_c[i_instr.ptr_begin] <= o_reg_p;
            end
            if (do_load_c) begin
                reg_c[i_instr.ptr_begin] <= i_instr.imm;
            end
            if (do_clr_hst) begin
                o_reg_hst <= o_reg_hst & ~i_instr.imm; // XM, SB, SR, MP bits
            end
            if (do_st_eq) begin
                o_reg_st[i_instr.ptr_begin] <= i_instr.imm[0];
            end
            if (do_set_mode) begin
                o_alu_mode <= i_instr.imm[0];
            end
        end
    end

    assign o_c_nibble = reg_c[i_c_ptr];

    // Architectural state only moves on a fire from the sequencer
    a_hold_without_fire: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_fire |=> $stable({o_reg_p, o_reg_hst, o_reg_st, o_alu_mode, reg_c}));

endmodule

`default_nettype wire

// File: verilog/saturn_pkg.sv
// Types shared by the Saturn control unit RTL and its testbench; import with saturn_pkg::*
`default_nettype none

`include "saturn_consts.svh"

package saturn_pkg;

    // Instruction classes delivered by the external decoder
    typedef enum logic [2:0] {
        INSTR_NOP,
        INSTR_ALU,
        INSTR_SET_MODE,
        INSTR_JUMP,
        INSTR_LOAD,
        INSTR_RESET
    } instr_type_e;

    typedef enum logic [1:0] {
        ALU_OP_COPY,
        ALU_OP_CLR_MASK
    } alu_op_e;

    // Register selectors for destination and source
    typedef enum logic [2:0] {
        ALU_REG_A,
        ALU_REG_C,
        ALU_REG_P,
        ALU_REG_ST,
        ALU_REG_HST,
        ALU_REG_IMM
    } alu_reg_e;

    // Commands understood by the bus controller, one nibble each
    typedef enum logic [3:0] {
        BUSCMD_PC_READ = 4'd0,
        BUSCMD_LOAD_PC = 4'd1,
        BUSCMD_RESET   = 4'd2
    } bus_cmd_e;

    typedef struct packed {
        instr_type_e                 instr_type;
        alu_op_e                     alu_op;
        alu_reg_e                    reg_dest;
        alu_reg_e                    reg_src;
        logic [`SATURN_NIBBLE_W-1:0] ptr_begin; // Nibble or bit pointer
        logic [`SATURN_NIBBLE_W-1:0] imm;       // Immediate value
    } dec_instr_t;

    // One bus program entry, nibble is a bus_cmd_e when is_cmd is set
    typedef struct packed {
        logic                        is_cmd;
        logic [`SATURN_NIBBLE_W-1:0] nibble;
    } prog_word_t;

    // Command sequencer states
    typedef enum logic [2:0] {
        SEQ_LOAD_CMD,
        SEQ_PC_NIBBLES,
        SEQ_READY,
        SEQ_PC_READ
    } seq_state_e;

endpackage

`default_nettype wire

// File: vlog.f
+incdir+include
+incdir+dv
verilog/saturn_pkg.sv
verilog/saturn_cmd_sequencer.sv
verilog/saturn_bus_program.sv
verilog/saturn_exec_regs.sv
verilog/saturn_control_unit.sv
dv/tb_saturn_control_unit.sv
